//--- rtl/lane_encoder_settings.svh
// FIFO depths and address widths of the byte-lane encoder
`ifndef LANE_ENCODER_SETTINGS_SVH
`define LANE_ENCODER_SETTINGS_SVH

// input word FIFO
`define RAW_FIFO_DEPTH 4
`define RAW_FIFO_AW    2

// output symbol FIFO, two fully strobed words
`define SYM_FIFO_DEPTH 8
`define SYM_FIFO_AW    3

`endif

//--- rtl/lane_types_pkg.sv
// data-path vector types for the byte-lane encoder
`default_nettype none

package lane_types_pkg;

	// one input word, four byte lanes with lane 0 in the low byte
	typedef logic [31:0] raw_word_t;

	// write strobe, bit n enables lane n
	typedef logic [3:0] wstrb_t;

	// tag of the source word, carried into every symbol
	typedef logic [3:0] word_index_t;

	// lane number within a word
	typedef logic [1:0] lane_t;

	// one lane byte
	typedef logic [7:0] byte_t;

	// encoded symbol, msb to lsb:
	//   [14:11] word index
	//   [10:9]  lane
	//   [8:1]   byte
	//   [0]     even parity over the byte
	typedef logic [14:0] symbol_t;

endpackage

`default_nettype wire

//--- rtl/lane_ctrl_pkg.sv
// state encoding of the encoder control FSM
`default_nettype none

package lane_ctrl_pkg;

	// one-hot, one bit per state
	typedef enum logic [6:0] {
		INIT     = 7'b000_0001,
		RD_READY = 7'b000_0010,
		RF_FULL  = 7'b000_0100,
		ENCODE_0 = 7'b000_1000,
		ENCODE_1 = 7'b001_0000,
		ENCODE_2 = 7'b010_0000,
		ENCODE_3 = 7'b100_0000
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/raw_word_fifo.sv
// input FIFO holding data, index and strobe of each word, head always visible
`timescale 1ns/1ns
`default_nettype none

`include "lane_encoder_settings.svh"

module raw_word_fifo
	import lane_types_pkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire         push,
	input  raw_word_t   push_data,
	input  word_index_t push_index,
	input  wstrb_t      push_wstrb,
	input  wire         pop,
	output logic        full,
	output logic        empty,
	output logic        taken,
	output raw_word_t   head_data,
	output word_index_t head_index,
	output wstrb_t      head_wstrb
);

	localparam int ENTRY_W = $bits(raw_word_t) + $bits(word_index_t) + $bits(wstrb_t);

	// one entry holds {data, index, strobe}
	logic [ENTRY_W-1:0] mem [`RAW_FIFO_DEPTH];

	logic [`RAW_FIFO_AW-1:0] wr_ptr;
	logic [`RAW_FIFO_AW-1:0] rd_ptr;
	logic [`RAW_FIFO_AW:0]   count;
	logic                    push_ok;

	assign full    = (count == (`RAW_FIFO_AW + 1)'(`RAW_FIFO_DEPTH));
	assign empty   = (count == '0);
	// writes into a full FIFO are dropped
	assign push_ok = push & ~full;
	assign taken   = pop & ~empty;

	assign {head_data, head_index, head_wstrb} = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push_ok)
			mem[wr_ptr] <= {push_data, push_index, push_wstrb};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (taken)
				rd_ptr <= rd_ptr + 1'b1;

			// simultaneous push and pop leaves the count unchanged
			case ({push_ok, taken})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/lane_encoder.sv
// word holding register and symbol builder for the selected lane
`timescale 1ns/1ns
`default_nettype none

module lane_encoder
	import lane_types_pkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire         load,
	input  raw_word_t   load_data,
	input  word_index_t load_index,
	input  wstrb_t      load_wstrb,
	input  lane_t       lane_sel,
	output symbol_t     sym_data,
	output logic        lane_strobed
);

	raw_word_t   word_q;
	word_index_t index_q;
	wstrb_t      wstrb_q;

	byte_t       sel_byte;
	logic        parity;

	// payload follows the FIFO head on each accepted pop
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			word_q  <= load_data;
			index_q <= load_index;
		end
	end

	// strobe bits of the held word
	always_ff @(posedge clk)
	begin
		if (reset)
			wstrb_q <= '0;
		else if (load)
			wstrb_q <= load_wstrb;
	end

	// lane n sits at bits 8n+7 .. 8n
	assign sel_byte     = word_q[{lane_sel, 3'b000} +: 8];
	assign lane_strobed = wstrb_q[lane_sel];

	// xor of the byte makes the total ones count even
	assign parity = ^sel_byte;

	assign sym_data = {index_q, lane_sel, sel_byte, parity};

endmodule

`default_nettype wire

//--- rtl/symbol_fifo.sv
// show-ahead output FIFO of encoded symbols, with synchronous clear
`timescale 1ns/1ns
`default_nettype none

`include "lane_encoder_settings.svh"

module symbol_fifo
	import lane_types_pkg::*;
(
	input  wire     clk,
	input  wire     reset,
	input  wire     clr,
	input  wire     push,
	input  symbol_t push_data,
	input  wire     pop,
	output logic    full,
	output logic    empty,
	output symbol_t head
);

	symbol_t mem [`SYM_FIFO_DEPTH];

	logic [`SYM_FIFO_AW-1:0] wr_ptr;
	logic [`SYM_FIFO_AW-1:0] rd_ptr;
	logic [`SYM_FIFO_AW:0]   count;
	logic                    push_ok;
	logic                    pop_ok;

	assign full  = (count == (`SYM_FIFO_AW + 1)'(`SYM_FIFO_DEPTH));
	assign empty = (count == '0);

	// push while full and pop while empty are both ignored
	assign push_ok = push & ~full;
	assign pop_ok  = pop & ~empty;

	// oldest symbol, valid whenever empty is low
	assign head = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push_ok)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk)
	begin
		if (reset || clr)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;

			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/encode_ctrl.sv
// one-hot control FSM: word pop, output full checks and lane writes
`timescale 1ns/1ns
`default_nettype none

module encode_ctrl
	import lane_types_pkg::*;
	import lane_ctrl_pkg::*;
(
	input  wire   clk,
	input  wire   reset,
	input  wire   raw_empty,
	input  wire   raw_taken,
	output logic  raw_pop,
	input  wire   sym_full,
	output logic  sym_clr,
	output lane_t lane_sel,
	output logic  lane_write,
	output logic  busy
);

	ctrl_state_t state;
	ctrl_state_t next_state;

	// next lane to encode
	lane_t lane_cnt;
	logic  lane_inc;
	logic  lane_clr;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= INIT;
			lane_cnt <= '0;
		end
		else
		begin
			state <= next_state;
			if (lane_clr)
				lane_cnt <= '0;
			else if (lane_inc)
				lane_cnt <= lane_cnt + 1'b1;
		end
	end

	assign lane_sel = lane_cnt;

	always_comb
	begin
		raw_pop    = 1'b0;
		sym_clr    = 1'b0;
		lane_write = 1'b0;
		busy       = 1'b0;
		lane_inc   = 1'b0;
		lane_clr   = 1'b0;
		next_state = state;

		case (state)
			INIT:
			begin
				// flush the output side once after reset
				sym_clr    = 1'b1;
				lane_clr   = 1'b1;
				next_state = RD_READY;
			end

			RD_READY:
			begin
				raw_pop = 1'b1;
				if (raw_empty)
					next_state = RD_READY;
				else if (raw_taken && sym_full)
					next_state = RF_FULL;
				else if (raw_taken)
					next_state = ENCODE_0;
			end

			RF_FULL:
			begin
				busy = 1'b1;
				// hold the lane until the output FIFO has room
				if (sym_full)
					next_state = RF_FULL;
				else
				begin
					case (lane_cnt)
						2'd0:    next_state = ENCODE_0;
						2'd1:    next_state = ENCODE_1;
						2'd2:    next_state = ENCODE_2;
						default: next_state = ENCODE_3;
					endcase
				end
			end

			ENCODE_0, ENCODE_1, ENCODE_2:
			begin
				busy       = 1'b1;
				lane_write = 1'b1;
				lane_inc   = 1'b1;
				next_state = RF_FULL;
			end

			ENCODE_3:
			begin
				busy       = 1'b1;
				lane_write = 1'b1;
				lane_clr   = 1'b1;
				next_state = RD_READY;
			end

			// corrupted one-hot value
			default:
				next_state = INIT;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/lane_encoder_top.sv
// byte-lane encoder top: input FIFO, lane encoder, control FSM, symbol FIFO
`timescale 1ns/1ns
`default_nettype none

module lane_encoder_top
	import lane_types_pkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire         word_push,
	input  raw_word_t   word_data,
	input  word_index_t word_index,
	input  wstrb_t      word_wstrb,
	output logic        word_full,
	input  wire         sym_pop,
	output symbol_t     sym_out,
	output logic        sym_empty,
	output logic        busy
);

	logic        raw_empty;
	logic        raw_pop;
	logic        raw_taken;
	raw_word_t   raw_head_data;
	word_index_t raw_head_index;
	wstrb_t      raw_head_wstrb;

	lane_t       lane_sel;
	symbol_t     sym_data;
	logic        lane_strobed;
	logic        lane_write;
	logic        sym_push;
	logic        sym_clr;
	logic        sym_full;

	// unstrobed lanes are stepped over without a write
	assign sym_push = lane_write & lane_strobed;

	raw_word_fifo u_raw_fifo (
		.clk        (clk),
		.reset      (reset),
		.push       (word_push),
		.push_data  (word_data),
		.push_index (word_index),
		.push_wstrb (word_wstrb),
		.pop        (raw_pop),
		.full       (word_full),
		.empty      (raw_empty),
		.taken      (raw_taken),
		.head_data  (raw_head_data),
		.head_index (raw_head_index),
		.head_wstrb (raw_head_wstrb)
	);

	lane_encoder u_encoder (
		.clk          (clk),
		.reset        (reset),
		.load         (raw_taken),
		.load_data    (raw_head_data),
		.load_index   (raw_head_index),
		.load_wstrb   (raw_head_wstrb),
		.lane_sel     (lane_sel),
		.sym_data     (sym_data),
		.lane_strobed (lane_strobed)
	);

	encode_ctrl u_ctrl (
		.clk        (clk),
		.reset      (reset),
		.raw_empty  (raw_empty),
		.raw_taken  (raw_taken),
		.raw_pop    (raw_pop),
		.sym_full   (sym_full),
		.sym_clr    (sym_clr),
		.lane_sel   (lane_sel),
		.lane_write (lane_write),
		.busy       (busy)
	);

	symbol_fifo u_sym_fifo (
		.clk       (clk),
		.reset     (reset),
		.clr       (sym_clr),
		.push      (sym_push),
		.push_data (sym_data),
		.pop       (sym_pop),
		.full      (sym_full),
		.empty     (sym_empty),
		.head      (sym_out)
	);

endmodule

`default_nettype wire

//--- verif/lane_encoder_tb.sv
// directed testbench for the byte-lane encoder with symbol model, compare tasks, LCG and timeout
`timescale 1ns/1ns
`default_nettype none

`include "lane_encoder_settings.svh"

module lane_encoder_tb
	import lane_types_pkg::*;
();

	localparam int CYCLE_LIMIT = 3000;
	localparam int RANDOM_WORDS = 40;
	// words needed to fill the output FIFO plus one that stalls
	localparam int STALL_WORDS = `SYM_FIFO_DEPTH / 4 + 1;
	// a full input FIFO plus the word in flight, 8 cycles each
	localparam int IDLE_CYCLES = (`RAW_FIFO_DEPTH + 1) * 8 + 4;

	logic        clk;
	logic        reset;
	logic        word_push;
	raw_word_t   word_data;
	word_index_t word_index;
	wstrb_t      word_wstrb;
	logic        word_full;
	logic        sym_pop;
	symbol_t     sym_out;
	logic        sym_empty;
	logic        busy;

	symbol_t     expected_q[$];
	logic [31:0] lcg_state;
	int          cycles = 0;

	lane_encoder_top UUT (
		.clk        (clk),
		.reset      (reset),
		.word_push  (word_push),
		.word_data  (word_data),
		.word_index (word_index),
		.word_wstrb (word_wstrb),
		.word_full  (word_full),
		.sym_pop    (sym_pop),
		.sym_out    (sym_out),
		.sym_empty  (sym_empty),
		.busy       (busy)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$fatal(1);
		end
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// expected symbols of one word in lane order
	function automatic void model_word(raw_word_t data, word_index_t index, wstrb_t wstrb);
		byte_t b;
		int    ones;
		for (int lane = 0; lane < 4; lane++)
		begin
			b = data[lane*8 +: 8];
			ones = 0;
			for (int i = 0; i < 8; i++)
				if (b[i])
					ones++;
			if (wstrb[lane])
				expected_q.push_back({index, lane_t'(lane), b, ones % 2 == 1});
		end
	endfunction

	task automatic check_symbol(string name, symbol_t actual, symbol_t expected);
		if (actual !== expected)
		begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_flag(string name, logic actual, logic expected);
		if (actual !== expected)
		begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic wait_cycles(int n);
		repeat (n) @(negedge clk);
	endtask

	// accepted tells whether the input FIFO has room for this word
	task automatic push_word(raw_word_t data, word_index_t index, wstrb_t wstrb, logic accepted);
		@(negedge clk);
		check_flag("word_full", word_full, ~accepted);
		word_data  = data;
		word_index = index;
		word_wstrb = wstrb;
		word_push  = 1'b1;
		if (accepted)
			model_word(data, index, wstrb);
		@(negedge clk);
		word_push = 1'b0;
	endtask

	task automatic drain_all();
		while (expected_q.size() > 0)
		begin
			@(negedge clk);
			sym_pop = 1'b0;
			if (!sym_empty)
			begin
				check_symbol("sym_out", sym_out, expected_q.pop_front());
				sym_pop = 1'b1;
			end
		end
		@(negedge clk);
		sym_pop = 1'b0;
	endtask

	task automatic settle_idle();
		wait_cycles(IDLE_CYCLES);
		check_flag("busy", busy, 1'b0);
		check_flag("sym_empty", sym_empty, 1'b1);
	endtask

	task automatic idle_after_reset();
		check_flag("sym_empty", sym_empty, 1'b1);
		check_flag("busy", busy, 1'b0);
		check_flag("word_full", word_full, 1'b0);
	endtask

	task automatic one_full_word();
		push_word(32'hA5_3C_0F_81, 4'h3, 4'b1111, 1'b1);
		drain_all();
		settle_idle();
	endtask

	task automatic partial_strobes();
		push_word(32'h12_34_56_78, 4'h9, 4'b0000, 1'b1);
		settle_idle();
		push_word(32'hFF_00_7E_01, 4'h1, 4'b0101, 1'b1);
		push_word(32'hDE_AD_BE_EF, 4'h2, 4'b1000, 1'b1);
		push_word(32'h80_C3_11_00, 4'h4, 4'b0110, 1'b1);
		drain_all();
		settle_idle();
	endtask

	task automatic output_back_pressure();
		for (int w = 0; w < STALL_WORDS; w++)
			push_word(next_rand(), word_index_t'(w + 5), 4'b1111, 1'b1);
		wait_cycles(40);
		check_flag("busy", busy, 1'b1);
		check_flag("sym_empty", sym_empty, 1'b0);
		drain_all();
		settle_idle();
	endtask

	task automatic input_overflow();
		for (int w = 0; w < STALL_WORDS; w++)
			push_word(next_rand(), word_index_t'(w), 4'b1111, 1'b1);
		wait_cycles(40);
		for (int w = 0; w < `RAW_FIFO_DEPTH; w++)
			push_word(next_rand(), word_index_t'(w + 8), 4'b1111, 1'b1);
		// input FIFO is full here, so this word is dropped
		push_word(next_rand(), 4'hF, 4'b1111, 1'b0);
		drain_all();
		settle_idle();
	endtask

	task automatic random_stream();
		int          sent;
		logic [31:0] rnd;
		sent = 0;
		while (sent < RANDOM_WORDS || expected_q.size() > 0)
		begin
			@(negedge clk);
			word_push = 1'b0;
			sym_pop   = 1'b0;
			if (sent < RANDOM_WORDS && !word_full)
			begin
				rnd        = next_rand();
				word_data  = next_rand();
				word_index = rnd[27:24];
				word_wstrb = rnd[31:28];
				word_push  = 1'b1;
				model_word(word_data, word_index, word_wstrb);
				sent++;
			end
			rnd = next_rand();
			if (!sym_empty && rnd[30])
			begin
				if (expected_q.size() == 0)
				begin
					$display("a symbol came out that the model does not expect");
					$display("TEST FAIL");
					$fatal(1);
				end
				check_symbol("sym_out", sym_out, expected_q.pop_front());
				sym_pop = 1'b1;
			end
		end
		@(negedge clk);
		word_push = 1'b0;
		sym_pop   = 1'b0;
		settle_idle();
	endtask

	initial
	begin
		lcg_state  = 32'h5db05250;
		reset      = 1'b1;
		word_push  = 1'b0;
		word_data  = '0;
		word_index = '0;
		word_wstrb = '0;
		sym_pop    = 1'b0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		wait_cycles(2);

		idle_after_reset();
		one_full_word();
		partial_strobes();
		output_back_pressure();
		input_overflow();
		random_stream();

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/lane_types_pkg.sv
rtl/lane_ctrl_pkg.sv
rtl/raw_word_fifo.sv
rtl/lane_encoder.sv
rtl/symbol_fifo.sv
rtl/encode_ctrl.sv
rtl/lane_encoder_top.sv
verif/lane_encoder_tb.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing
TOP        ?= lane_encoder_tb
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
